/* common/or1k_decode_defines.svh */
`ifndef OR1K_DECODE_DEFINES_SVH
`define OR1K_DECODE_DEFINES_SVH

// Instruction word
`define OR1K_INSN_WIDTH     32
`define OR1K_OPCODE_MSB     31
`define OR1K_OPCODE_LSB     26

// Register fields
`define OR1K_RD_MSB         25
`define OR1K_RD_LSB         21
`define OR1K_RA_MSB         20
`define OR1K_RA_LSB         16
`define OR1K_RB_MSB         15
`define OR1K_RB_LSB         11
`define OR1K_RF_ADDR_WIDTH  5

`define OR1K_IMM_WIDTH      16

// ALU opcode sits in bits 3..0
`define OR1K_ALU_OPC_WIDTH  4
`define OR1K_ALU_SEC_MSB    7
`define OR1K_ALU_SEC_LSB    6
`define OR1K_COMP_MSB       24
`define OR1K_COMP_LSB       21
`define OR1K_SYSTRAP_MSB    25
`define OR1K_SYSTRAP_LSB    21

// Return address register for l.jal and l.jalr
`define OR1K_LINK_REG       9

`endif

/* common/or1k_decode_pkg.sv */
`include "or1k_decode_defines.svh"

package or1k_decode_pkg;

   // Major opcodes, bits 31..26
   typedef enum logic [`OR1K_OPCODE_MSB-`OR1K_OPCODE_LSB:0] {
      OPC_J           = 6'h00,
      OPC_JAL         = 6'h01,
      OPC_BNF         = 6'h03,
      OPC_BF          = 6'h04,
      OPC_NOP         = 6'h05,
      OPC_MOVHI       = 6'h06,
      OPC_SYSTRAPSYNC = 6'h08,
      OPC_RFE         = 6'h09,
      OPC_JR          = 6'h11,
      OPC_JALR        = 6'h12,
      OPC_MACI        = 6'h13,
      OPC_LWA         = 6'h1b,
      OPC_CUST1       = 6'h1c,
      OPC_CUST2       = 6'h1d,
      OPC_CUST3       = 6'h1e,
      OPC_CUST4       = 6'h1f,
      OPC_LD          = 6'h20,
      OPC_LWZ         = 6'h21,
      OPC_LWS         = 6'h22,
      OPC_LBZ         = 6'h23,
      OPC_LBS         = 6'h24,
      OPC_LHZ         = 6'h25,
      OPC_LHS         = 6'h26,
      OPC_ADDI        = 6'h27,
      OPC_ADDIC       = 6'h28,
      OPC_ANDI        = 6'h29,
      OPC_ORI         = 6'h2a,
      OPC_XORI        = 6'h2b,
      OPC_MULI        = 6'h2c,
      OPC_MFSPR       = 6'h2d,
      OPC_SHRTI       = 6'h2e,
      OPC_SFIMM       = 6'h2f,
      OPC_MTSPR       = 6'h30,
      OPC_MAC         = 6'h31,
      OPC_FPU         = 6'h32,
      OPC_SWA         = 6'h33,
      OPC_SD          = 6'h34,
      OPC_SW          = 6'h35,
      OPC_SB          = 6'h36,
      OPC_SH          = 6'h37,
      OPC_ALU         = 6'h38,
      OPC_SF          = 6'h39,
      OPC_CUST5       = 6'h3c,
      OPC_CUST6       = 6'h3d,
      OPC_CUST7       = 6'h3e,
      OPC_CUST8       = 6'h3f
   } opcode_e;

   // ALU field of the l.alu opcode group
   typedef enum logic [`OR1K_ALU_OPC_WIDTH-1:0] {
      ALU_ADD   = 4'h0,
      ALU_ADDC  = 4'h1,
      ALU_SUB   = 4'h2,
      ALU_AND   = 4'h3,
      ALU_OR    = 4'h4,
      ALU_XOR   = 4'h5,
      ALU_MUL   = 4'h6,
      ALU_SHRT  = 4'h8,
      ALU_DIV   = 4'h9,
      ALU_DIVU  = 4'ha,
      ALU_MULU  = 4'hb,
      ALU_EXTBH = 4'hc,
      ALU_EXTW  = 4'hd,
      ALU_CMOV  = 4'he,
      ALU_FFL1  = 4'hf
   } alu_opc_e;

   typedef enum logic [`OR1K_ALU_SEC_MSB-`OR1K_ALU_SEC_LSB:0] {
      SHRT_SLL = 2'd0,
      SHRT_SRL = 2'd1,
      SHRT_SRA = 2'd2,
      SHRT_ROR = 2'd3
   } shrt_opc_e;

   typedef enum logic [`OR1K_SYSTRAP_MSB-`OR1K_SYSTRAP_LSB:0] {
      SYSTRAP_SYSCALL = 5'b00000,
      SYSTRAP_TRAP    = 5'b01000,
      SYSTRAP_MSYNC   = 5'b10000,
      SYSTRAP_PSYNC   = 5'b10100,
      SYSTRAP_CSYNC   = 5'b11000
   } systrap_opc_e;

   typedef enum logic [1:0] {
      LSU_BYTE = 2'd0,
      LSU_HALF = 2'd1,
      LSU_WORD = 2'd2
   } lsu_len_e;

endpackage

/* decode/or1k_op_class.sv */
`timescale 1ns/1ps
`include "or1k_decode_defines.svh"

module or1k_op_class (
   input  logic [`OR1K_INSN_WIDTH-1:0] insn_i,
   output logic                        op_load_o,
   output logic                        op_store_o,
   output logic                        op_atomic_o,
   output logic                        op_alu_o,
   output logic                        op_setflag_o,
   output logic                        op_jbr_o,
   output logic                        op_jr_o,
   output logic                        op_jal_o,
   output logic                        op_bf_o,
   output logic                        op_bnf_o,
   output logic                        op_mfspr_o,
   output logic                        op_mtspr_o,
   output logic                        op_rfe_o,
   output logic                        op_mul_o,
   output logic                        op_shift_o,
   output logic                        op_movhi_o,
   output or1k_decode_pkg::lsu_len_e   lsu_len_o,
   output logic                        lsu_zext_o,
   output logic                        rf_wb_o
);
   import or1k_decode_pkg::*;

   opcode_e  opc;
   alu_opc_e alu_fn;
   logic     is_alu_grp;

   assign opc        = opcode_e'(insn_i[`OR1K_OPCODE_MSB:`OR1K_OPCODE_LSB]);
   assign alu_fn     = alu_opc_e'(insn_i[`OR1K_ALU_OPC_WIDTH-1:0]);
   assign is_alu_grp = (opc == OPC_ALU);

   // 0x20 to 0x26 are the plain loads
   assign op_load_o   = ((opc[5:3] == 3'b100) && (opc[2:0] != 3'b111)) || (opc == OPC_LWA);
   assign op_store_o  = (opc == OPC_SW) || (opc == OPC_SB) || (opc == OPC_SH) ||
                        (opc == OPC_SWA);
   assign op_atomic_o = (opc == OPC_LWA) || (opc == OPC_SWA);

   assign op_alu_o     = is_alu_grp || (opc == OPC_ORI) || (opc == OPC_ANDI) ||
                         (opc == OPC_XORI);
   assign op_setflag_o = (opc == OPC_SF) || (opc == OPC_SFIMM);

   // J, JAL, BNF and BF all sit below NOP
   assign op_jbr_o   = (opc < OPC_NOP);
   assign op_jr_o    = (opc == OPC_JR) || (opc == OPC_JALR);
   assign op_jal_o   = (opc == OPC_JAL) || (opc == OPC_JALR);
   assign op_bf_o    = (opc == OPC_BF);
   assign op_bnf_o   = (opc == OPC_BNF);
   assign op_mfspr_o = (opc == OPC_MFSPR);
   assign op_mtspr_o = (opc == OPC_MTSPR);
   assign op_rfe_o   = (opc == OPC_RFE);
   assign op_movhi_o = (opc == OPC_MOVHI);

   assign op_mul_o   = (is_alu_grp && ((alu_fn == ALU_MUL) || (alu_fn == ALU_MULU))) ||
                       (opc == OPC_MULI);
   assign op_shift_o = (is_alu_grp && (alu_fn == ALU_SHRT)) || (opc == OPC_SHRTI);

   always_comb begin
      case (opc)
         OPC_SB, OPC_LBZ, OPC_LBS: lsu_len_o = LSU_BYTE;
         OPC_SH, OPC_LHZ, OPC_LHS: lsu_len_o = LSU_HALF;
         default:                  lsu_len_o = LSU_WORD;
      endcase
   end

   // Odd load opcodes are the zero-extending ones
   assign lsu_zext_o = opc[0];

   assign rf_wb_o = (opc == OPC_JAL) || (opc == OPC_JALR) || (opc == OPC_MOVHI) ||
                    (opc == OPC_LWA) ||
                    ((opc[5:4] == 2'b10) && (opc != OPC_SFIMM)) ||
                    ((opc[5:4] == 2'b11) && !((opc == OPC_SF) || op_mtspr_o || op_store_o));

endmodule

/* decode/or1k_operand_decode.sv */
`timescale 1ns/1ps
`include "or1k_decode_defines.svh"

module or1k_operand_decode (
   input  logic [`OR1K_INSN_WIDTH-1:0]    insn_i,
   input  logic                           op_store_i,
   input  logic                           op_mtspr_i,
   input  logic                           op_jal_i,
   output logic [`OR1K_RF_ADDR_WIDTH-1:0] rfd_adr_o,
   output logic [`OR1K_RF_ADDR_WIDTH-1:0] rfa_adr_o,
   output logic [`OR1K_RF_ADDR_WIDTH-1:0] rfb_adr_o,
   output logic [`OR1K_INSN_WIDTH-1:0]    immediate_o,
   output logic                           immediate_sel_o
);
   import or1k_decode_pkg::*;

   localparam int PAD_WIDTH = `OR1K_INSN_WIDTH - `OR1K_IMM_WIDTH;

   opcode_e                     opc;
   logic [`OR1K_IMM_WIDTH-1:0]  imm16;
   logic                        sext_sel, zext_sel, high_sel;

   assign opc = opcode_e'(insn_i[`OR1K_OPCODE_MSB:`OR1K_OPCODE_LSB]);

   assign rfa_adr_o = insn_i[`OR1K_RA_MSB:`OR1K_RA_LSB];
   assign rfb_adr_o = insn_i[`OR1K_RB_MSB:`OR1K_RB_LSB];
   assign rfd_adr_o = op_jal_i ? `OR1K_RF_ADDR_WIDTH'(`OR1K_LINK_REG) :
                                 insn_i[`OR1K_RD_MSB:`OR1K_RD_LSB];

   // Stores and l.mtspr split the immediate around the rB field
   assign imm16 = (op_store_i || op_mtspr_i) ? {insn_i[25:21], insn_i[10:0]} :
                                               insn_i[`OR1K_IMM_WIDTH-1:0];

   assign sext_sel = ((opc[5:4] == 2'b10) && (opc != OPC_ORI) && (opc != OPC_ANDI)) ||
                     op_store_i || (opc == OPC_LWA);
   assign zext_sel = (opc == OPC_ORI) || (opc == OPC_ANDI) || op_mtspr_i;
   assign high_sel = (opc == OPC_MOVHI);

   assign immediate_o = sext_sel ? {{PAD_WIDTH{imm16[`OR1K_IMM_WIDTH-1]}}, imm16} :
                        zext_sel ? {{PAD_WIDTH{1'b0}}, imm16} :
                                   {imm16, {PAD_WIDTH{1'b0}}};

   assign immediate_sel_o = sext_sel || zext_sel || high_sel;

endmodule

/* decode/or1k_alu_ctrl.sv */
`timescale 1ns/1ps
`include "or1k_decode_defines.svh"

module or1k_alu_ctrl (
   input  logic [`OR1K_INSN_WIDTH-1:0]    insn_i,
   input  logic                           op_setflag_i,
   output or1k_decode_pkg::alu_opc_e      alu_opc_o,
   output logic [`OR1K_ALU_OPC_WIDTH-1:0] alu_opc_secondary_o,
   output logic                           op_add_o,
   output logic                           adder_do_sub_o
);
   import or1k_decode_pkg::*;

   opcode_e   opc;
   alu_opc_e  alu_fn;
   shrt_opc_e shrt_kind;
   logic      is_alu_grp;

   assign opc        = opcode_e'(insn_i[`OR1K_OPCODE_MSB:`OR1K_OPCODE_LSB]);
   assign alu_fn     = alu_opc_e'(insn_i[`OR1K_ALU_OPC_WIDTH-1:0]);
   assign shrt_kind  = shrt_opc_e'(insn_i[`OR1K_ALU_SEC_MSB:`OR1K_ALU_SEC_LSB]);
   assign is_alu_grp = (opc == OPC_ALU);

   // Logic immediates carry no ALU field of their own
   assign alu_opc_o = (opc == OPC_ORI)  ? ALU_OR  :
                      (opc == OPC_ANDI) ? ALU_AND :
                      (opc == OPC_XORI) ? ALU_XOR : alu_fn;

   assign alu_opc_secondary_o = op_setflag_i ? insn_i[`OR1K_COMP_MSB:`OR1K_COMP_LSB] :
                                               {2'b00, shrt_kind};

   assign op_add_o = (is_alu_grp && ((alu_fn == ALU_ADD) || (alu_fn == ALU_SUB))) ||
                     (opc == OPC_ADDI);

   // Compares run through the adder as a subtract
   assign adder_do_sub_o = (is_alu_grp && (alu_fn == ALU_SUB)) || op_setflag_i;

endmodule

/* decode/or1k_illegal_check.sv */
`timescale 1ns/1ps
`include "or1k_decode_defines.svh"

module or1k_illegal_check (
   input  logic [`OR1K_INSN_WIDTH-1:0] insn_i,
   output logic                        except_illegal_o,
   output logic                        except_syscall_o,
   output logic                        except_trap_o
);
   import or1k_decode_pkg::*;

   opcode_e      opc;
   alu_opc_e     alu_fn;
   shrt_opc_e    shrt_kind;
   systrap_opc_e systrap;
   logic         shrt_legal;

   assign opc       = opcode_e'(insn_i[`OR1K_OPCODE_MSB:`OR1K_OPCODE_LSB]);
   assign alu_fn    = alu_opc_e'(insn_i[`OR1K_ALU_OPC_WIDTH-1:0]);
   assign shrt_kind = shrt_opc_e'(insn_i[`OR1K_ALU_SEC_MSB:`OR1K_ALU_SEC_LSB]);
   assign systrap   = systrap_opc_e'(insn_i[`OR1K_SYSTRAP_MSB:`OR1K_SYSTRAP_LSB]);

   // No rotate unit, SRA is present
   assign shrt_legal = (shrt_kind != SHRT_ROR);

   always_comb begin
      case (opc)
         OPC_J, OPC_JAL, OPC_BNF, OPC_BF, OPC_NOP, OPC_MOVHI, OPC_RFE,
         OPC_JR, OPC_JALR,
         OPC_LWZ, OPC_LWS, OPC_LBZ, OPC_LBS, OPC_LHZ, OPC_LHS,
         OPC_ADDI, OPC_ANDI, OPC_ORI, OPC_XORI, OPC_MULI, OPC_MFSPR,
         OPC_SFIMM, OPC_MTSPR, OPC_SW, OPC_SB, OPC_SH, OPC_SF,
         OPC_LWA, OPC_SWA: begin
            except_illegal_o = 1'b0;
         end
         OPC_SHRTI: begin
            except_illegal_o = !shrt_legal;
         end
         OPC_ALU: begin
            case (alu_fn)
               ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
               ALU_MUL, ALU_MULU: begin
                  except_illegal_o = 1'b0;
               end
               ALU_SHRT: begin
                  except_illegal_o = !shrt_legal;
               end
               // Divider, carry, extend, cmov and ff1 are not built
               default: begin
                  except_illegal_o = 1'b1;
               end
            endcase
         end
         OPC_SYSTRAPSYNC: begin
            except_illegal_o = !((systrap == SYSTRAP_SYSCALL) ||
                                 (systrap == SYSTRAP_TRAP) ||
                                 (systrap == SYSTRAP_MSYNC));
         end
         // MAC, FPU, custom and 64-bit memory ops land here
         default: begin
            except_illegal_o = 1'b1;
         end
      endcase
   end

   assign except_syscall_o = (opc == OPC_SYSTRAPSYNC) && (systrap == SYSTRAP_SYSCALL);
   assign except_trap_o    = (opc == OPC_SYSTRAPSYNC) && (systrap == SYSTRAP_TRAP);

endmodule

/* hdl/or1k_decode.sv */
`timescale 1ns/1ps
`include "or1k_decode_defines.svh"

module or1k_decode (
   input  logic                            clk,
   input  logic                            reset_i,
   input  logic                            insn_valid_i,
   input  logic [`OR1K_INSN_WIDTH-1:0]     insn_i,
   output logic                            valid_o,
   output logic                            op_load_o,
   output logic                            op_store_o,
   output logic                            op_atomic_o,
   output logic                            op_alu_o,
   output logic                            op_setflag_o,
   output logic                            op_jbr_o,
   output logic                            op_jr_o,
   output logic                            op_jal_o,
   output logic                            op_bf_o,
   output logic                            op_bnf_o,
   output logic                            op_mfspr_o,
   output logic                            op_mtspr_o,
   output logic                            op_rfe_o,
   output logic                            op_add_o,
   output logic                            op_mul_o,
   output logic                            op_shift_o,
   output logic                            op_movhi_o,
   output or1k_decode_pkg::lsu_len_e       lsu_len_o,
   output logic                            lsu_zext_o,
   output logic                            rf_wb_o,
   output logic [`OR1K_RF_ADDR_WIDTH-1:0]  rfd_adr_o,
   output logic [`OR1K_RF_ADDR_WIDTH-1:0]  rfa_adr_o,
   output logic [`OR1K_RF_ADDR_WIDTH-1:0]  rfb_adr_o,
   output logic [`OR1K_INSN_WIDTH-1:0]     immediate_o,
   output logic                            immediate_sel_o,
   output or1k_decode_pkg::alu_opc_e       alu_opc_o,
   output logic [`OR1K_ALU_OPC_WIDTH-1:0]  alu_opc_secondary_o,
   output logic                            adder_do_sub_o,
   output logic                            except_illegal_o,
   output logic                            except_syscall_o,
   output logic                            except_trap_o
);
   import or1k_decode_pkg::*;

   localparam int NUM_STROBES = 21;

   logic op_load, op_store, op_atomic, op_alu, op_setflag, op_jbr, op_jr, op_jal;
   logic op_bf, op_bnf, op_mfspr, op_mtspr, op_rfe, op_add, op_mul, op_shift;
   logic op_movhi, rf_wb, lsu_zext, immediate_sel, adder_do_sub;
   logic except_illegal, except_syscall, except_trap;
   lsu_len_e                        lsu_len;
   alu_opc_e                        alu_opc;
   logic [`OR1K_ALU_OPC_WIDTH-1:0]  alu_opc_secondary;
   logic [`OR1K_RF_ADDR_WIDTH-1:0]  rfd_adr, rfa_adr, rfb_adr;
   logic [`OR1K_INSN_WIDTH-1:0]     immediate;
   logic [NUM_STROBES-1:0]          strb_d, strb_q;

   or1k_op_class u_op_class (
      .insn_i       (insn_i),
      .op_load_o    (op_load),
      .op_store_o   (op_store),
      .op_atomic_o  (op_atomic),
      .op_alu_o     (op_alu),
      .op_setflag_o (op_setflag),
      .op_jbr_o     (op_jbr),
      .op_jr_o      (op_jr),
      .op_jal_o     (op_jal),
      .op_bf_o      (op_bf),
      .op_bnf_o     (op_bnf),
      .op_mfspr_o   (op_mfspr),
      .op_mtspr_o   (op_mtspr),
      .op_rfe_o     (op_rfe),
      .op_mul_o     (op_mul),
      .op_shift_o   (op_shift),
      .op_movhi_o   (op_movhi),
      .lsu_len_o    (lsu_len),
      .lsu_zext_o   (lsu_zext),
      .rf_wb_o      (rf_wb)
   );

   or1k_operand_decode u_operand_decode (
      .insn_i          (insn_i),
      .op_store_i      (op_store),
      .op_mtspr_i      (op_mtspr),
      .op_jal_i        (op_jal),
      .rfd_adr_o       (rfd_adr),
      .rfa_adr_o       (rfa_adr),
      .rfb_adr_o       (rfb_adr),
      .immediate_o     (immediate),
      .immediate_sel_o (immediate_sel)
   );

   or1k_alu_ctrl u_alu_ctrl (
      .insn_i              (insn_i),
      .op_setflag_i        (op_setflag),
      .alu_opc_o           (alu_opc),
      .alu_opc_secondary_o (alu_opc_secondary),
      .op_add_o            (op_add),
      .adder_do_sub_o      (adder_do_sub)
   );

   or1k_illegal_check u_illegal_check (
      .insn_i           (insn_i),
      .except_illegal_o (except_illegal),
      .except_syscall_o (except_syscall),
      .except_trap_o    (except_trap)
   );

   // Strobes that must drop on reset and on empty cycles
   assign strb_d = {op_load, op_store, op_atomic, op_alu, op_setflag, op_jbr, op_jr,
                    op_jal, op_bf, op_bnf, op_mfspr, op_mtspr, op_rfe, op_add, op_mul,
                    op_shift, op_movhi, rf_wb, except_illegal, except_syscall,
                    except_trap};

   always_ff @(posedge clk) begin
      if (reset_i) begin
         valid_o <= 1'b0;
         strb_q  <= '0;
      end else begin
         valid_o <= insn_valid_i;
         strb_q  <= insn_valid_i ? strb_d : '0;
      end
   end

   assign {op_load_o, op_store_o, op_atomic_o, op_alu_o, op_setflag_o, op_jbr_o, op_jr_o,
           op_jal_o, op_bf_o, op_bnf_o, op_mfspr_o, op_mtspr_o, op_rfe_o, op_add_o,
           op_mul_o, op_shift_o, op_movhi_o, rf_wb_o, except_illegal_o,
           except_syscall_o, except_trap_o} = strb_q;

   // Operand fields only move on a valid instruction
   always_ff @(posedge clk) begin
      if (insn_valid_i) begin
         lsu_len_o           <= lsu_len;
         lsu_zext_o          <= lsu_zext;
         rfd_adr_o           <= rfd_adr;
         rfa_adr_o           <= rfa_adr;
         rfb_adr_o           <= rfb_adr;
         immediate_o         <= immediate;
         immediate_sel_o     <= immediate_sel;
         alu_opc_o           <= alu_opc;
         alu_opc_secondary_o <= alu_opc_secondary;
         adder_do_sub_o      <= adder_do_sub;
      end
   end

endmodule

/* verification/or1k_decode_props.sv */
`timescale 1ns/1ps

module or1k_decode_props (
   input logic        clk,
   input logic        reset_i,
   input logic        valid_i,
   input logic [20:0] strobes_i,
   input logic        load_i,
   input logic        store_i
);

   // An empty slot carries no operation or exception
   a_quiet_when_idle: assert property (@(posedge clk) disable iff (reset_i)
      !valid_i |-> (strobes_i == '0))
      else $error("decode strobe high while valid_o is low");

   a_load_store_excl: assert property (@(posedge clk) disable iff (reset_i)
      !(load_i && store_i))
      else $error("op_load_o and op_store_o high together");

   // Reset empties the execute-stage register
   a_reset_clears: assert property (@(posedge clk)
      reset_i |=> (!valid_i && (strobes_i == '0)))
      else $error("decode register not cleared by reset");

endmodule

bind or1k_decode or1k_decode_props i_props (
   .clk       (clk),
   .reset_i   (reset_i),
   .valid_i   (valid_o),
   .strobes_i ({op_load_o, op_store_o, op_atomic_o, op_alu_o, op_setflag_o, op_jbr_o,
                op_jr_o, op_jal_o, op_bf_o, op_bnf_o, op_mfspr_o, op_mtspr_o, op_rfe_o,
                op_add_o, op_mul_o, op_shift_o, op_movhi_o, rf_wb_o, except_illegal_o,
                except_syscall_o, except_trap_o}),
   .load_i    (op_load_o),
   .store_i   (op_store_o)
);

/* verification/or1k_decode_tb.sv */
`timescale 1ns/1ps
`include "or1k_decode_defines.svh"

module or1k_decode_tb;
   import or1k_decode_pkg::*;

   localparam int NUM_RAND = 32;

   // Flag bits from high to low are load store atomic setflag wb sub zext imm_sel
   typedef struct packed {
      logic [31:0] insn;
      logic [7:0]  flags;
      lsu_len_e    len;
      logic [4:0]  rfd;
      logic [31:0] imm;
      alu_opc_e    alu;
      logic [3:0]  sec;
      logic [2:0]  exc;   // illegal, syscall, trap
   } row_t;

   logic        clk = 1'b0;
   logic        reset_i;
   logic        insn_valid_i;
   logic [31:0] insn_i;
   logic        valid_o, op_load_o, op_store_o, op_atomic_o, op_alu_o, op_setflag_o;
   logic        op_jbr_o, op_jr_o, op_jal_o, op_bf_o, op_bnf_o, op_mfspr_o, op_mtspr_o;
   logic        op_rfe_o, op_add_o, op_mul_o, op_shift_o, op_movhi_o, lsu_zext_o, rf_wb_o;
   lsu_len_e    lsu_len_o;
   logic [4:0]  rfd_adr_o, rfa_adr_o, rfb_adr_o;
   logic [31:0] immediate_o;
   logic        immediate_sel_o;
   alu_opc_e    alu_opc_o;
   logic [3:0]  alu_opc_secondary_o;
   logic        adder_do_sub_o, except_illegal_o, except_syscall_o, except_trap_o;

   row_t rows[$];
   int   cycles = 0;
   int   max_cycles;

   or1k_decode i_or1k_decode (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Instruction formats with rA = 4 and rB = 5
   function automatic logic [31:0] enc_i(input logic [5:0] opc, input logic [4:0] rd,
                                         input logic [15:0] imm);
      return {opc, rd, 5'd4, imm};
   endfunction

   function automatic logic [31:0] enc_r(input logic [5:0] opc, input logic [4:0] rd,
                                         input logic [10:0] lo);
      return {opc, rd, 5'd4, 5'd5, lo};
   endfunction

   // Store form splits the immediate around rB
   function automatic logic [31:0] enc_s(input logic [5:0] opc, input logic [15:0] imm);
      return {opc, imm[15:11], 5'd4, 5'd5, imm[10:0]};
   endfunction

   task automatic add_row(input logic [31:0] insn, input logic [7:0] flags,
                          input lsu_len_e len, input logic [4:0] rfd, input logic [31:0] imm,
                          input alu_opc_e alu, input logic [3:0] sec, input logic [2:0] exc);
      row_t r;
      r.insn  = insn;
      r.flags = flags;
      r.len   = len;
      r.rfd   = rfd;
      r.imm   = imm;
      r.alu   = alu;
      r.sec   = sec;
      r.exc   = exc;
      rows.push_back(r);
   endtask

   task automatic build_table();
      // Loads and stores
      add_row(enc_i(OPC_LWZ, 3, 16'h0010), 8'b10001011, LSU_WORD, 3, 32'h10, ALU_ADD, 0, 3'b000);
      add_row(enc_i(OPC_LBS, 3, 16'hfff0), 8'b10001001, LSU_BYTE, 3, 32'hfffffff0, ALU_ADD, 3,
              3'b000);
      add_row(enc_i(OPC_LHZ, 3, 16'h0002), 8'b10001011, LSU_HALF, 3, 32'h2, ALU_SUB, 0, 3'b000);
      add_row(enc_i(OPC_LWA, 3, 16'h8000), 8'b10101011, LSU_WORD, 3, 32'hffff8000, ALU_ADD, 0,
              3'b000);
      add_row(enc_s(OPC_SW, 16'h7ff4), 8'b01000011, LSU_WORD, 15, 32'h7ff4, ALU_OR, 3, 3'b000);
      add_row(enc_s(OPC_SB, 16'hfffe), 8'b01000001, LSU_BYTE, 31, 32'hfffffffe, ALU_CMOV, 3,
              3'b000);
      add_row(enc_s(OPC_SH, 16'h0006), 8'b01000011, LSU_HALF, 0, 32'h6, ALU_MUL, 0, 3'b000);
      add_row(enc_s(OPC_SWA, 16'h0000), 8'b01100011, LSU_WORD, 0, 32'h0, ALU_ADD, 0, 3'b000);
      // Immediate forms and the link register
      add_row(enc_i(OPC_ADDI, 3, 16'hff9c), 8'b00001011, LSU_WORD, 3, 32'hffffff9c, ALU_EXTBH,
              2, 3'b000);
      add_row(enc_i(OPC_ORI, 3, 16'h8001), 8'b00001001, LSU_WORD, 3, 32'h8001, ALU_OR, 0, 3'b000);
      add_row(enc_i(OPC_MOVHI, 3, 16'hbeef), 8'b00001001, LSU_WORD, 3, 32'hbeef0000, ALU_FFL1,
              3, 3'b000);
      add_row(enc_i(OPC_JAL, 0, 16'h0040), 8'b00001010, LSU_WORD, 9, 32'h0, ALU_ADD, 1, 3'b000);
      // ALU group with legal and unbuilt functions
      add_row(enc_r(OPC_ALU, 3, 11'h000), 8'b00001000, LSU_WORD, 3, 0, ALU_ADD, 0, 3'b000);
      add_row(enc_r(OPC_ALU, 3, 11'h002), 8'b00001100, LSU_WORD, 3, 0, ALU_SUB, 0, 3'b000);
      add_row(enc_r(OPC_ALU, 3, 11'h00b), 8'b00001000, LSU_WORD, 3, 0, ALU_MULU, 0, 3'b000);
      add_row(enc_r(OPC_ALU, 3, 11'h009), 8'b00001000, LSU_WORD, 3, 0, ALU_DIV, 0, 3'b100);
      add_row(enc_r(OPC_ALU, 3, 11'h001), 8'b00001000, LSU_WORD, 3, 0, ALU_ADDC, 0, 3'b100);
      add_row(enc_r(OPC_ALU, 3, 11'h00e), 8'b00001000, LSU_WORD, 3, 0, ALU_CMOV, 0, 3'b100);
      add_row(enc_r(OPC_ALU, 3, 11'h00f), 8'b00001000, LSU_WORD, 3, 0, ALU_FFL1, 0, 3'b100);
      add_row(enc_r(OPC_ALU, 3, 11'h00d), 8'b00001000, LSU_WORD, 3, 0, ALU_EXTW, 0, 3'b100);
      add_row(enc_r(OPC_ALU, 3, 11'h088), 8'b00001000, LSU_WORD, 3, 0, ALU_SHRT, 2, 3'b000);
      add_row(enc_r(OPC_ALU, 3, 11'h0c8), 8'b00001000, LSU_WORD, 3, 0, ALU_SHRT, 3, 3'b100);
      add_row(enc_i(OPC_SHRTI, 3, 16'h0005), 8'b00001001, LSU_WORD, 3, 32'h5, ALU_XOR, 0, 3'b000);
      add_row(enc_i(OPC_SHRTI, 3, 16'h00c5), 8'b00001001, LSU_WORD, 3, 32'hc5, ALU_XOR, 3,
              3'b100);
      add_row(enc_i(OPC_MULI, 3, 16'h0003), 8'b00001001, LSU_WORD, 3, 32'h3, ALU_AND, 0, 3'b000);
      // Opcodes of units that are not present
      add_row(enc_i(OPC_ADDIC, 3, 16'h0001), 8'b00001001, LSU_WORD, 3, 32'h1, ALU_ADDC, 0, 3'b100);
      add_row(enc_r(OPC_FPU, 3, 11'h000), 8'b00001000, LSU_WORD, 3, 0, ALU_ADD, 0, 3'b100);
      add_row(enc_r(OPC_CUST1, 3, 11'h000), 8'b00000000, LSU_WORD, 3, 0, ALU_ADD, 0, 3'b100);
      add_row(enc_i(OPC_LD, 3, 16'h0008), 8'b10001001, LSU_WORD, 3, 32'h8, ALU_SHRT, 0, 3'b100);
      add_row(enc_r(OPC_SD, 3, 11'h000), 8'b00001000, LSU_WORD, 3, 0, ALU_ADD, 0, 3'b100);
      add_row(enc_r(OPC_MAC, 3, 11'h000), 8'b00001010, LSU_WORD, 3, 0, ALU_ADD, 0, 3'b100);
      add_row(enc_r(6'h0a, 3, 11'h000), 8'b00000000, LSU_WORD, 3, 0, ALU_ADD, 0, 3'b100);
      // Compares, then system call, trap and the sync group
      add_row(enc_r(OPC_SF, 3, 11'h000), 8'b00010110, LSU_WORD, 3, 0, ALU_ADD, 3, 3'b000);
      add_row(enc_i(OPC_SFIMM, 12, 16'h0010), 8'b00010111, LSU_WORD, 12, 32'h10, ALU_ADD, 12,
              3'b000);
      add_row(enc_i(OPC_SYSTRAPSYNC, 0, 16'h0001), 8'b0, LSU_WORD, 0, 0, ALU_ADDC, 0, 3'b010);
      add_row(enc_i(OPC_SYSTRAPSYNC, 8, 16'h0001), 8'b0, LSU_WORD, 8, 0, ALU_ADDC, 0, 3'b001);
      add_row(enc_i(OPC_SYSTRAPSYNC, 16, 16'h0001), 8'b0, LSU_WORD, 16, 0, ALU_ADDC, 0, 3'b000);
      add_row(enc_i(OPC_SYSTRAPSYNC, 20, 16'h0001), 8'b0, LSU_WORD, 20, 0, ALU_ADDC, 0, 3'b100);
      add_row(enc_i(OPC_SYSTRAPSYNC, 24, 16'h0001), 8'b0, LSU_WORD, 24, 0, ALU_ADDC, 0, 3'b100);
   endtask

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp)
         fail_now($sformatf("error at %0t ns: %s expected %b got %b", $time, what, exp, got));
   endtask

   task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp)
         fail_now($sformatf("error at %0t ns: %s expected %h got %h", $time, what, exp, got));
   endtask

   task automatic check_adr(input logic [4:0] got, input logic [4:0] exp, input string what);
      if (got !== exp)
         fail_now($sformatf("error at %0t ns: %s expected r%0d got r%0d", $time, what, exp, got));
   endtask

   task automatic check_alu_opc(input alu_opc_e got, input alu_opc_e exp, input string what);
      if (got !== exp)
         fail_now($sformatf("error at %0t ns: %s expected %s got %h", $time, what, exp.name(),
                            got));
   endtask

   task automatic check_len(input lsu_len_e got, input lsu_len_e exp, input string what);
      if (got !== exp)
         fail_now($sformatf("error at %0t ns: %s expected %s got %h", $time, what, exp.name(),
                            got));
   endtask

   task automatic check_quiet(input string when);
      check_bit(valid_o, 1'b0, {when, " valid_o"});
      check_word({11'b0, op_load_o, op_store_o, op_atomic_o, op_alu_o, op_setflag_o, op_jbr_o,
                  op_jr_o, op_jal_o, op_bf_o, op_bnf_o, op_mfspr_o, op_mtspr_o, op_rfe_o,
                  op_add_o, op_mul_o, op_shift_o, op_movhi_o, rf_wb_o, except_illegal_o,
                  except_syscall_o, except_trap_o}, 32'h0, {when, " strobes"});
   endtask

   task automatic check_row(input row_t r, input int idx);
      string tag;
      tag = $sformatf("row %0d (%h)", idx, r.insn);
      check_bit(valid_o, 1'b1, {tag, " valid_o"});
      check_bit(op_load_o, r.flags[7], {tag, " op_load_o"});
      check_bit(op_store_o, r.flags[6], {tag, " op_store_o"});
      check_bit(op_atomic_o, r.flags[5], {tag, " op_atomic_o"});
      check_bit(op_setflag_o, r.flags[4], {tag, " op_setflag_o"});
      check_bit(rf_wb_o, r.flags[3], {tag, " rf_wb_o"});
      check_bit(adder_do_sub_o, r.flags[2], {tag, " adder_do_sub_o"});
      check_bit(lsu_zext_o, r.flags[1], {tag, " lsu_zext_o"});
      check_bit(immediate_sel_o, r.flags[0], {tag, " immediate_sel_o"});
      check_len(lsu_len_o, r.len, {tag, " lsu_len_o"});
      check_adr(rfd_adr_o, r.rfd, {tag, " rfd_adr_o"});
      check_adr(rfa_adr_o, r.insn[20:16], {tag, " rfa_adr_o"});
      check_adr(rfb_adr_o, r.insn[15:11], {tag, " rfb_adr_o"});
      if (r.flags[0])
         check_word(immediate_o, r.imm, {tag, " immediate_o"});
      check_alu_opc(alu_opc_o, r.alu, {tag, " alu_opc_o"});
      check_word({28'b0, alu_opc_secondary_o}, {28'b0, r.sec}, {tag, " alu_opc_secondary_o"});
      check_bit(except_illegal_o, r.exc[2], {tag, " except_illegal_o"});
      check_bit(except_syscall_o, r.exc[1], {tag, " except_syscall_o"});
      check_bit(except_trap_o, r.exc[0], {tag, " except_trap_o"});
   endtask

   // Run length guard
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= max_cycles)
         fail_now($sformatf("Timeout: the run did not finish within %0d cycles", max_cycles));
   end

   initial begin
      int seed;
      int rnd;
      seed         = 65;
      reset_i      = 1'b1;
      // Reset has to clear the register even with a valid load on the inputs
      insn_valid_i = 1'b1;
      insn_i       = enc_i(OPC_LWA, 5'd3, 16'h0004);
      build_table();
      max_cycles = 16 + 2 * (rows.size() + NUM_RAND) + 20;

      repeat (16) @(posedge clk);
      #2;
      reset_i = 1'b0;
      check_quiet("after reset");

      // Rows go back to back and each is checked one cycle later
      foreach (rows[i]) begin
         insn_valid_i = 1'b1;
         insn_i       = rows[i].insn;
         @(posedge clk);
         #2;
         check_row(rows[i], i);
      end

      // Operand fields hold while a different word sits on the inputs
      insn_valid_i = 1'b0;
      insn_i       = enc_i(OPC_ORI, 5'd7, 16'h1234);
      @(posedge clk);
      #2;
      check_quiet("idle cycle");
      check_adr(rfd_adr_o, rows[rows.size()-1].rfd, "idle cycle rfd_adr_o hold");
      check_alu_opc(alu_opc_o, rows[rows.size()-1].alu, "idle cycle alu_opc_o hold");

      // Random words with a random valid pattern
      for (int n = 0; n < NUM_RAND; n++) begin
         rnd          = $random(seed);
         insn_i       = rnd;
         rnd          = $random(seed);
         insn_valid_i = rnd[0];
         @(posedge clk);
         #2;
         check_bit(valid_o, insn_valid_i, $sformatf("random word %0d valid_o", n));
      end

      insn_valid_i = 1'b0;
      @(posedge clk);
      #2;
      check_quiet("final idle cycle");
      $display("TB PASSED");
      $finish;
   end

endmodule

/* files.f */
+incdir+common
common/or1k_decode_pkg.sv
decode/or1k_op_class.sv
decode/or1k_operand_decode.sv
decode/or1k_alu_ctrl.sv
decode/or1k_illegal_check.sv
hdl/or1k_decode.sv
verification/or1k_decode_props.sv
verification/or1k_decode_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module or1k_decode_tb \
   -f files.f -o or1k_decode_sim || { echo "Verilator build failed"; exit 1; }
./obj_dir/or1k_decode_sim > sim.log 2>&1
cat sim.log
grep -q "TB FAILED" sim.log && echo "Simulation reported a failure" && exit 1
grep -q "TB PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation finished cleanly"
exit 0
